//--- source/mod_exp_pkg.sv
package mod_exp_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------

    // one transferred word on the streams
    localparam int WORD_W    = 8;
    // words per operand, moved low word first
    localparam int NUM_WORDS = 4;
    localparam int OPERAND_W = WORD_W * NUM_WORDS;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [OPERAND_W-1:0] operand_t;

    // ------------------------------------------------------------------
    // job and context
    // ------------------------------------------------------------------

    // one loaded job, modulus must be odd and above base
    typedef struct packed {
        operand_t modulus;
        operand_t base;
        operand_t exponent;
    } exp_job_t;

    // job plus the montgomery constants for its modulus
    typedef struct packed {
        exp_job_t job;
        // R mod m, montgomery form of one
        operand_t r_mod;
        // R^2 mod m, converts an operand into montgomery form
        operand_t r2_mod;
    } exp_ctx_t;

endpackage

//--- source/operand_loader.sv
`timescale 1ns/1ns

module operand_loader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mod_exp_pkg::word_t    in_word,
    input  logic                  in_valid,
    output logic                  in_ready,
    output mod_exp_pkg::exp_job_t job,
    output logic                  job_valid,
    input  logic                  job_ready
);

    // modulus, base, exponent in that order
    localparam int JOB_WORDS = 3 * mod_exp_pkg::NUM_WORDS;
    localparam int CNT_W     = $clog2(JOB_WORDS);
    localparam int HI        = mod_exp_pkg::OPERAND_W - 1;
    localparam int LO        = mod_exp_pkg::WORD_W;

    logic [CNT_W-1:0] cnt;
    logic             accept;
    logic             last_word;

    assign accept    = in_valid && in_ready;
    assign last_word = (cnt == CNT_W'(JOB_WORDS - 1));

    // stall input while a finished job waits
    assign in_ready = !job_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            job_valid <= 1'b0;
        end else if (accept) begin
            cnt <= last_word ? '0 : cnt + 1'b1;
            if (last_word) begin
                job_valid <= 1'b1;
            end
        end else if (job_valid && job_ready) begin
            job_valid <= 1'b0;
        end
    end

    // words enter at the top and move down, low word ends at bit 0
    always_ff @(posedge clk) begin
        if (accept) begin
            case (cnt / mod_exp_pkg::NUM_WORDS)
                0:       job.modulus  <= {in_word, job.modulus[HI:LO]};
                1:       job.base     <= {in_word, job.base[HI:LO]};
                default: job.exponent <= {in_word, job.exponent[HI:LO]};
            endcase
        end
    end

endmodule

//--- source/mont_const_gen.sv
`timescale 1ns/1ns

module mont_const_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mod_exp_pkg::exp_job_t job,
    input  logic                  job_valid,
    output logic                  job_ready,
    output mod_exp_pkg::exp_ctx_t ctx,
    output logic                  ctx_valid,
    input  logic                  ctx_ready
);

    localparam int W      = mod_exp_pkg::OPERAND_W;
    // 2^(2W) mod m needs 2W doublings
    localparam int STEPS  = 2 * W;
    localparam int STEP_W = $clog2(STEPS + 1);

    logic                  busy;
    logic [STEP_W-1:0]     step;
    mod_exp_pkg::operand_t acc;
    logic [W:0]            dbl;
    mod_exp_pkg::operand_t dbl_red;
    logic                  take;

    assign take      = job_valid && job_ready;
    assign job_ready = !busy && !ctx_valid;

    // ------------------------------------------------------------------
    // modular doubling, acc stays below m
    // ------------------------------------------------------------------
    assign dbl = {acc, 1'b0};

    always_comb begin
        if (dbl >= {1'b0, ctx.job.modulus}) begin
            dbl_red = W'(dbl - {1'b0, ctx.job.modulus});
        end else begin
            dbl_red = dbl[W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            step      <= '0;
            ctx_valid <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            // one extra cycle after the last doubling to latch r2
            if (step == STEP_W'(STEPS)) begin
                busy      <= 1'b0;
                ctx_valid <= 1'b1;
            end else begin
                step <= step + 1'b1;
            end
        end else if (ctx_valid && ctx_ready) begin
            ctx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ctx.job <= job;
            acc     <= mod_exp_pkg::operand_t'(1);
        end else if (busy) begin
            if (step < STEP_W'(STEPS)) begin
                acc <= dbl_red;
            end
            // after W doublings the value is R mod m
            if (step == STEP_W'(W - 1)) begin
                ctx.r_mod <= dbl_red;
            end
            if (step == STEP_W'(STEPS)) begin
                ctx.r2_mod <= acc;
            end
        end
    end

endmodule

//--- source/mont_mult.sv
`timescale 1ns/1ns

module mont_mult (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mul_start,
    input  mod_exp_pkg::operand_t mul_a,
    input  mod_exp_pkg::operand_t mul_b,
    input  mod_exp_pkg::operand_t mul_m,
    output logic                  mul_done,
    output mod_exp_pkg::operand_t mul_p
);

    localparam int W     = mod_exp_pkg::OPERAND_W;
    localparam int CNT_W = $clog2(W);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_SUB
    } state_t;

    state_t                state;
    logic [CNT_W-1:0]      bit_cnt;
    mod_exp_pkg::operand_t a_sh;
    mod_exp_pkg::operand_t b_q;
    mod_exp_pkg::operand_t m_q;
    // partial sum, kept below 2m
    logic [W:0]            acc;
    logic [W+1:0]          sum_b;
    logic [W+1:0]          sum_m;

    // add b when the bit is set, add m when odd, then halve
    assign sum_b = {1'b0, acc} + (a_sh[0] ? {2'b00, b_q} : '0);
    assign sum_m = sum_b + (sum_b[0] ? {2'b00, m_q} : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (mul_start) begin
                        state   <= S_RUN;
                        bit_cnt <= '0;
                    end
                end
                S_RUN: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(W - 1)) begin
                        state <= S_SUB;
                    end
                end
                default: begin
                    state    <= S_IDLE;
                    mul_done <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && mul_start) begin
            a_sh <= mul_a;
            b_q  <= mul_b;
            m_q  <= mul_m;
            acc  <= '0;
        end else if (state == S_RUN) begin
            a_sh <= a_sh >> 1;
            acc  <= sum_m[W+1:1];
        end else if (state == S_SUB) begin
            // final subtraction
            mul_p <= (acc >= {1'b0, m_q}) ? W'(acc - {1'b0, m_q}) : acc[W-1:0];
        end
    end

endmodule

//--- source/exp_sequencer.sv
`timescale 1ns/1ns

module exp_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mod_exp_pkg::exp_ctx_t ctx,
    input  logic                  ctx_valid,
    output logic                  ctx_ready,
    output mod_exp_pkg::operand_t res,
    output logic                  res_valid,
    input  logic                  res_ready
);

    localparam int W     = mod_exp_pkg::OPERAND_W;
    localparam int CNT_W = $clog2(W);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CONV,
        S_SQR,
        S_MUL,
        S_FINAL,
        S_HOLD
    } state_t;

    state_t                state;
    logic                  pending;
    logic [CNT_W-1:0]      bit_cnt;
    mod_exp_pkg::exp_ctx_t ctx_q;
    mod_exp_pkg::operand_t base_m;
    mod_exp_pkg::operand_t acc;
    mod_exp_pkg::operand_t exp_sh;
    logic                  in_product;
    logic                  step_done;
    logic                  bit_adv;
    logic                  last_bit;
    logic                  mul_start;
    mod_exp_pkg::operand_t mul_a;
    mod_exp_pkg::operand_t mul_b;
    logic                  mul_done;
    mod_exp_pkg::operand_t mul_p;

    assign ctx_ready  = (state == S_IDLE);
    assign res_valid  = (state == S_HOLD);
    assign in_product = (state == S_CONV) || (state == S_SQR) ||
                        (state == S_MUL) || (state == S_FINAL);
    assign mul_start  = in_product && !pending;
    assign step_done  = pending && mul_done;
    assign last_bit   = (bit_cnt == CNT_W'(W - 1));
    // bit finished: square with a zero bit, or the multiply after it
    assign bit_adv    = step_done &&
                        ((state == S_SQR && !exp_sh[W-1]) || state == S_MUL);

    // ------------------------------------------------------------------
    // operand select per phase
    // ------------------------------------------------------------------
    always_comb begin
        case (state)
            S_CONV: begin
                mul_a = ctx_q.job.base;
                mul_b = ctx_q.r2_mod;
            end
            S_MUL: begin
                mul_a = acc;
                mul_b = base_m;
            end
            S_FINAL: begin
                // times one leaves montgomery form
                mul_a = acc;
                mul_b = mod_exp_pkg::operand_t'(1);
            end
            default: begin
                mul_a = acc;
                mul_b = acc;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            pending <= 1'b0;
            bit_cnt <= '0;
        end else begin
            if (mul_start) begin
                pending <= 1'b1;
            end else if (step_done) begin
                pending <= 1'b0;
            end
            case (state)
                S_IDLE:  if (ctx_valid) state <= S_CONV;
                S_CONV:  if (step_done) begin
                    state   <= S_SQR;
                    bit_cnt <= '0;
                end
                S_SQR:   if (step_done && exp_sh[W-1]) state <= S_MUL;
                S_FINAL: if (step_done) state <= S_HOLD;
                S_HOLD:  if (res_ready) state <= S_IDLE;
                default: ;
            endcase
            if (bit_adv) begin
                bit_cnt <= bit_cnt + 1'b1;
                state   <= last_bit ? S_FINAL : S_SQR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctx_valid && ctx_ready) begin
            ctx_q  <= ctx;
            exp_sh <= ctx.job.exponent;
        end
        if (step_done) begin
            case (state)
                S_CONV: begin
                    base_m <= mul_p;
                    // accumulator starts at one in montgomery form
                    acc    <= ctx_q.r_mod;
                end
                S_FINAL: res <= mul_p;
                default: acc <= mul_p;
            endcase
        end
        // msb first
        if (bit_adv) begin
            exp_sh <= exp_sh << 1;
        end
    end

    mont_mult i_mont_mult (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .mul_m     (ctx_q.job.modulus),
        .mul_done  (mul_done),
        .mul_p     (mul_p)
    );

endmodule

//--- source/result_serializer.sv
`timescale 1ns/1ns

module result_serializer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mod_exp_pkg::operand_t res,
    input  logic                  res_valid,
    output logic                  res_ready,
    output mod_exp_pkg::word_t    out_word,
    output logic                  out_valid,
    output logic                  out_last,
    input  logic                  out_ready
);

    localparam int CNT_W = $clog2(mod_exp_pkg::NUM_WORDS);

    logic [CNT_W-1:0]      cnt;
    mod_exp_pkg::operand_t shreg;
    logic                  take;
    logic                  sent;

    // take a new result only once the previous one is fully out
    assign res_ready = !out_valid;
    assign take      = res_valid && res_ready;
    assign sent      = out_valid && out_ready;

    // both come from registers, so stable during a stall
    assign out_word = shreg[mod_exp_pkg::WORD_W-1:0];
    assign out_last = (cnt == CNT_W'(mod_exp_pkg::NUM_WORDS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            cnt       <= '0;
        end else if (take) begin
            out_valid <= 1'b1;
            cnt       <= '0;
        end else if (sent) begin
            cnt <= cnt + 1'b1;
            if (out_last) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            shreg <= res;
        end else if (sent) begin
            shreg <= shreg >> mod_exp_pkg::WORD_W;
        end
    end

endmodule

//--- source/mod_exp_top.sv
`timescale 1ns/1ns

module mod_exp_top (
    input  logic               clk,
    input  logic               rst_n,
    input  mod_exp_pkg::word_t in_word,
    input  logic               in_valid,
    output logic               in_ready,
    output mod_exp_pkg::word_t out_word,
    output logic               out_valid,
    output logic               out_last,
    input  logic               out_ready
);

    // ------------------------------------------------------------------
    // inter-stage links
    // ------------------------------------------------------------------
    mod_exp_pkg::exp_job_t job;
    logic                  job_valid;
    logic                  job_ready;
    mod_exp_pkg::exp_ctx_t ctx;
    logic                  ctx_valid;
    logic                  ctx_ready;
    mod_exp_pkg::operand_t res;
    logic                  res_valid;
    logic                  res_ready;

    operand_loader i_loader (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .job       (job),
        .job_valid (job_valid),
        .job_ready (job_ready)
    );

    // constants for the next job while the sequencer runs
    mont_const_gen i_const_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .job       (job),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .ctx       (ctx),
        .ctx_valid (ctx_valid),
        .ctx_ready (ctx_ready)
    );

    exp_sequencer i_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctx       (ctx),
        .ctx_valid (ctx_valid),
        .ctx_ready (ctx_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    result_serializer i_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

//--- verification/mod_exp_tb.sv
`timescale 1ns/1ns

module mod_exp_tb;

    localparam int W  = mod_exp_pkg::OPERAND_W;
    localparam int WW = mod_exp_pkg::WORD_W;
    localparam int NW = mod_exp_pkg::NUM_WORDS;
    // wait bounds in clock cycles
    // one product takes about W+3 cycles
    localparam int WORD_TIMEOUT  = 10000;
    localparam int DRAIN_TIMEOUT = 60000;

    logic               clk;
    logic               rst_n;
    mod_exp_pkg::word_t in_word;
    logic               in_valid;
    logic               in_ready;
    mod_exp_pkg::word_t out_word;
    logic               out_valid;
    logic               out_last;
    logic               out_ready;

    mod_exp_pkg::operand_t exp_q[$];
    mod_exp_pkg::operand_t got;
    int                    word_idx;
    int                    err_cnt;
    int                    chk_cnt;
    bit                    timed_out;
    bit                    bp_en;

    mod_exp_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // protocol checks
    // ----------------------------------------------------------------------
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_word) && $stable(out_last)))
        else begin
            $display("output word dropped or changed while stalled at %0t", $time);
            err_cnt++;
        end

    reset_values: assert property (@(posedge clk) !rst_n |-> (!out_valid && in_ready))
        else begin
            $display("wrong out_valid or in_ready during reset at %0t", $time);
            err_cnt++;
        end

    // ----------------------------------------------------------------------
    // reference model and stimulus
    // ----------------------------------------------------------------------
    function automatic mod_exp_pkg::operand_t pow_mod(input mod_exp_pkg::operand_t b,
                                                      input mod_exp_pkg::operand_t e,
                                                      input mod_exp_pkg::operand_t m);
        logic [2*W-1:0] r;
        logic [2*W-1:0] bb;
        logic [2*W-1:0] mm;
        r    = '0;
        r[0] = 1'b1;
        bb   = {{W{1'b0}}, b};
        mm   = {{W{1'b0}}, m};
        // msb first square-and-multiply
        for (int i = W - 1; i >= 0; i--) begin
            r = (r * r) % mm;
            if (e[i]) begin
                r = (r * bb) % mm;
            end
        end
        return r[W-1:0];
    endfunction

    task automatic send_word(input mod_exp_pkg::word_t w);
        int wait_cnt;
        wait_cnt = 0;
        if (!timed_out) begin
            in_word  = w;
            in_valid = 1'b1;
            @(negedge clk);
            while (!in_ready && wait_cnt < WORD_TIMEOUT) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (!in_ready) begin
                $display("timeout: in_ready stayed low for %0d cycles", wait_cnt);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // modulus then base then exponent with each low word first
    task automatic send_job(input mod_exp_pkg::operand_t m,
                            input mod_exp_pkg::operand_t b,
                            input mod_exp_pkg::operand_t e);
        logic [3*W-1:0] words;
        words = {e, b, m};
        exp_q.push_back(pow_mod(b, e, m));
        for (int k = 0; k < 3 * NW; k++) begin
            send_word(words[k*WW +: WW]);
        end
    endtask

    task automatic send_random_job(input bit rand_exp, input mod_exp_pkg::operand_t e_fixed);
        mod_exp_pkg::operand_t m;
        mod_exp_pkg::operand_t b;
        mod_exp_pkg::operand_t e;
        m        = mod_exp_pkg::operand_t'($urandom);
        m[W-1]   = 1'b1;
        m[0]     = 1'b1;
        b        = mod_exp_pkg::operand_t'($urandom) % m;
        e        = rand_exp ? mod_exp_pkg::operand_t'($urandom) : e_fixed;
        send_job(m, b, e);
    endtask

    task automatic drain_results();
        int wait_cnt;
        wait_cnt = 0;
        in_valid = 1'b0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_TIMEOUT && !timed_out) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0 && !timed_out) begin
            $display("timeout: %0d results never arrived", exp_q.size());
            timed_out = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int err_before);
        string verdict;
        verdict = (err_cnt == err_before && !timed_out) ? "ok" : "failed";
        $display("test %s %s, %0d errors", name, verdict, err_cnt - err_before);
    endtask

    // random stall pattern on the output side
    initial begin
        logic [31:0] rnd;
        forever begin
            @(posedge clk);
            #1;
            if (bp_en) begin
                rnd       = $urandom;
                out_ready = rnd[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // output collector sampling mid-cycle where everything is settled
    // ----------------------------------------------------------------------
    initial begin
        logic                  last_exp;
        mod_exp_pkg::operand_t expv;
        got      = '0;
        word_idx = 0;
        forever begin
            @(negedge clk);
            if (rst_n && out_valid && out_ready) begin
                last_exp = (word_idx == NW - 1);
                assert (out_last == last_exp) else begin
                    $display("MISMATCH out_last expected 0x%0h got 0x%0h", last_exp, out_last);
                    err_cnt++;
                end
                got[word_idx*WW +: WW] = out_word;
                if (word_idx == NW - 1) begin
                    word_idx = 0;
                    if (exp_q.size() == 0) begin
                        $display("result 0x%h arrived with no job outstanding", got);
                        err_cnt++;
                    end else begin
                        expv = exp_q.pop_front();
                        chk_cnt++;
                        assert (got == expv) else begin
                            $display("MISMATCH out_word result expected 0x%h got 0x%h",
                                     expv, got);
                            err_cnt++;
                        end
                    end
                end else begin
                    word_idx++;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        int err_before;
        void'($urandom(1));
        in_word   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        bp_en     = 1'b0;
        err_cnt   = 0;
        chk_cnt   = 0;
        timed_out = 1'b0;
        err_before = err_cnt;
        rst_n     = 1'b1;
        #1 rst_n  = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n  = 1'b1;

        @(negedge clk);
        assert (!out_valid) else begin
            $display("MISMATCH out_valid expected 0x0 got 0x%0h", out_valid);
            err_cnt++;
        end
        assert (in_ready) else begin
            $display("MISMATCH in_ready expected 0x1 got 0x%0h", in_ready);
            err_cnt++;
        end
        @(posedge clk);
        #1;
        report_test("reset_state", err_before);

        err_before = err_cnt;
        send_random_job(1'b1, '0);
        drain_results();
        report_test("single_job", err_before);

        err_before = err_cnt;
        send_random_job(1'b0, '0);
        send_random_job(1'b0, mod_exp_pkg::operand_t'(1));
        send_random_job(1'b0, '1);
        drain_results();
        report_test("edge_exponents", err_before);

        err_before = err_cnt;
        bp_en = 1'b1;
        repeat (4) send_random_job(1'b1, '0);
        drain_results();
        bp_en = 1'b0;
        report_test("back_pressure", err_before);

        err_before = err_cnt;
        repeat (8) send_random_job(1'b1, '0);
        drain_results();
        report_test("back_to_back", err_before);

        $display("results checked %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
source/mod_exp_pkg.sv
source/operand_loader.sv
source/mont_const_gen.sv
source/mont_mult.sv
source/exp_sequencer.sv
source/result_serializer.sv
source/mod_exp_top.sv
verification/mod_exp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the modular exponentiator testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module mod_exp_tb -f filelist.f -o mod_exp_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mod_exp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
exit 1
